// File: crc_stream.f
+incdir+common
common/crc_pkg.sv
hw/crc_engine.sv
hw/crc_append/crc_append.sv
hw/crc_check/crc_check.sv
hw/crc_stream_top.sv
sim/crc_stream_tb.sv

// File: Bender.yml
package:
  name: crc_stream

sources:
  - include_dirs:
      - common
    files:
      - common/crc_pkg.sv
      - hw/crc_engine.sv
      - hw/crc_append/crc_append.sv
      - hw/crc_check/crc_check.sv
      - hw/crc_stream_top.sv

  - target: simulation
    include_dirs:
      - common
    files:
      - sim/crc_stream_tb.sv

// File: sim/crc_stream_tb.sv
/* drives the transmit and receive paths of crc_stream_top from queued frames;
   rx frames are the expected tx frames, optionally with one flipped bit */

`timescale 1ns/1ps
`default_nettype none

`include "crc_defs.svh"

module crc_stream_tb;

    import crc_pkg::*;

    localparam int MAX_WORDS     = 12 + `CRC_WORDS;
    localparam int DRAIN_TIMEOUT = 5000;

    logic                   m_axis;
    logic                   rst;
    stream_beat_t           tx_in_beat;
    logic                   tx_in_valid;
    logic                   tx_in_ready;
    stream_beat_t           tx_out_beat;
    logic                   tx_out_valid;
    logic                   tx_out_ready;
    stream_beat_t           rx_in_beat;
    logic                   rx_in_valid;
    logic                   rx_in_ready;
    check_beat_t            rx_out_beat;
    logic                   rx_out_valid;
    logic                   rx_out_ready;

    stream_beat_t           tx_stim[$];
    stream_beat_t           rx_stim[$];
    stream_beat_t           tx_exp[$];
    check_beat_t            rx_exp[$];
    logic [`CRC_DATA_W-1:0] frame_words[0:MAX_WORDS-1];
    logic [31:0]            main_seed;
    logic [31:0]            tx_seed;
    logic [31:0]            rx_seed;
    logic [31:0]            rdy_seed;
    logic                   stall_on;
    logic                   gaps_on;
    logic                   timed_out;
    int                     errors;
    int                     checks;

    crc_stream_top dut (
        .m_axis       (m_axis),
        .rst          (rst),
        .tx_in_beat   (tx_in_beat),
        .tx_in_valid  (tx_in_valid),
        .tx_in_ready  (tx_in_ready),
        .tx_out_beat  (tx_out_beat),
        .tx_out_valid (tx_out_valid),
        .tx_out_ready (tx_out_ready),
        .rx_in_beat   (rx_in_beat),
        .rx_in_valid  (rx_in_valid),
        .rx_in_ready  (rx_in_ready),
        .rx_out_beat  (rx_out_beat),
        .rx_out_valid (rx_out_valid),
        .rx_out_ready (rx_out_ready)
    );

    initial begin
        m_axis = 1'b0;
        forever #2 m_axis = ~m_axis;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers and reference CRC
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] next_rand(inout logic [31:0] state);
        state = state * 32'd1664525 + 32'd1013904223;
        return state;
    endfunction

    function automatic logic [63:0] poly_for_width(input int width);
        case (width)
            8:       return 64'h07;
            16:      return 64'h1021;
            32:      return 64'h04C1_1DB7;
            default: return 64'h1B;
        endcase
    endfunction

    // shift register form over frame_words[0 .. len-1], MSB of each word first
    function automatic logic [`CRC_W-1:0] ref_crc(input int len);
        logic [`CRC_W-1:0] crc;
        logic [63:0]       poly_full;
        logic              top;
        crc       = `CRC_SEED;
        poly_full = poly_for_width(`CRC_W);
        for (int w = 0; w < len; w++) begin
            for (int b = `CRC_DATA_W - 1; b >= 0; b--) begin
                top = crc[`CRC_W-1] ^ frame_words[w][b];
                crc = crc << 1;
                if (top) begin
                    crc = crc ^ poly_full[`CRC_W-1:0];
                end
            end
        end
        return crc;
    endfunction

    // builds one frame and queues its stimulus and expected words
    task automatic queue_frame(input int len, input bit to_tx, input bit to_rx,
                               input bit corrupt);
        logic [`CRC_W-1:0] crc_val;
        logic [31:0]       rnd;
        stream_beat_t      sb;
        check_beat_t       cb;
        int                total;
        int                idx;
        total = len + `CRC_WORDS;
        for (int i = 0; i < len; i++) begin
            rnd            = next_rand(main_seed);
            frame_words[i] = `CRC_DATA_W'(rnd >> 8);
        end
        crc_val = ref_crc(len);
        for (int k = 0; k < `CRC_WORDS; k++) begin
            frame_words[len + k] = crc_val[(`CRC_WORDS - 1 - k) * `CRC_DATA_W +: `CRC_DATA_W];
        end
        if (to_tx) begin
            for (int i = 0; i < total; i++) begin
                sb.data = frame_words[i];
                sb.last = (i == len - 1);
                if (i < len) begin
                    tx_stim.push_back(sb);
                end
                sb.last = (i == total - 1);
                tx_exp.push_back(sb);
            end
        end
        if (to_rx) begin
            if (corrupt) begin
                rnd = next_rand(main_seed);
                idx = rnd[15:0] % total;
                frame_words[idx][rnd[27:20] % `CRC_DATA_W] ^= 1'b1;
            end
            for (int i = 0; i < total; i++) begin
                sb.data   = frame_words[i];
                sb.last   = (i == total - 1);
                cb.beat   = sb;
                cb.crc_ok = (i == total - 1) && !corrupt;
                rx_stim.push_back(sb);
                rx_exp.push_back(cb);
            end
        end
    endtask

    task automatic queue_random(input int count, input bit to_tx, input bit to_rx,
                                input bit corrupt_odd);
        logic [31:0] rnd;
        for (int f = 0; f < count; f++) begin
            rnd = next_rand(main_seed);
            queue_frame(1 + rnd[19:16] % 12, to_tx, to_rx, corrupt_odd && (f % 2 == 1));
        end
    endtask

    task automatic wait_drained(input string what);
        int cycles;
        cycles = 0;
        while ((tx_stim.size() + rx_stim.size() + tx_exp.size() + rx_exp.size()) != 0
               && cycles < DRAIN_TIMEOUT) begin
            @(negedge m_axis);
            cycles++;
        end
        if ((tx_stim.size() + rx_stim.size() + tx_exp.size() + rx_exp.size()) != 0) begin
            $display("timeout: %s did not drain all words within %0d cycles",
                     what, DRAIN_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic report_test(input string name, input int err0, input int chk0);
        if (errors == err0 && !timed_out) begin
            $display("test %s: pass, %0d checks", name, checks - chk0);
        end else begin
            $display("test %s: fail, %0d errors in %0d checks", name, errors - err0,
                     checks - chk0);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drivers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // a held word stays until it is accepted, gaps only open between words
    always @(posedge m_axis) begin : tx_drive
        logic [31:0]  r;
        stream_beat_t sb;
        r = next_rand(tx_seed);
        if (rst) begin
            tx_in_valid <= 1'b0;
        end else if (!tx_in_valid || tx_in_ready) begin
            if (tx_stim.size() > 0 && !(gaps_on && r[9:8] == 2'b00)) begin
                sb = tx_stim.pop_front();
                tx_in_beat  <= sb;
                tx_in_valid <= 1'b1;
            end else begin
                tx_in_valid <= 1'b0;
            end
        end
    end

    always @(posedge m_axis) begin : rx_drive
        logic [31:0]  r;
        stream_beat_t sb;
        r = next_rand(rx_seed);
        if (rst) begin
            rx_in_valid <= 1'b0;
        end else if (!rx_in_valid || rx_in_ready) begin
            if (rx_stim.size() > 0 && !(gaps_on && r[9:8] == 2'b00)) begin
                sb = rx_stim.pop_front();
                rx_in_beat  <= sb;
                rx_in_valid <= 1'b1;
            end else begin
                rx_in_valid <= 1'b0;
            end
        end
    end

    always @(posedge m_axis) begin : ready_drive
        logic [31:0] r;
        r = next_rand(rdy_seed);
        tx_out_ready <= stall_on ? (r[12:11] != 2'b00) : 1'b1;
        rx_out_ready <= stall_on ? (r[22:21] != 2'b00) : 1'b1;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparison of both output streams
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge m_axis) begin : compare
        stream_beat_t te;
        check_beat_t  re;
        if (!rst && tx_out_valid && tx_out_ready) begin
            checks++;
            assert (tx_exp.size() > 0) else begin
                errors++;
                $display("** Error at %0d ns: tx_out word %h with none expected",
                         $time, tx_out_beat.data);
            end
            if (tx_exp.size() > 0) begin
                te = tx_exp.pop_front();
                assert (tx_out_beat == te) else begin
                    errors++;
                    $display("** Error at %0d ns: tx_out %h last %b, expected %h last %b",
                             $time, tx_out_beat.data, tx_out_beat.last, te.data, te.last);
                end
            end
        end
        if (!rst && rx_out_valid && rx_out_ready) begin
            checks++;
            assert (rx_exp.size() > 0) else begin
                errors++;
                $display("** Error at %0d ns: rx_out word %h with none expected",
                         $time, rx_out_beat.beat.data);
            end
            if (rx_exp.size() > 0) begin
                re = rx_exp.pop_front();
                assert (rx_out_beat.beat == re.beat) else begin
                    errors++;
                    $display("** Error at %0d ns: rx_out %h last %b, expected %h last %b",
                             $time, rx_out_beat.beat.data, rx_out_beat.beat.last,
                             re.beat.data, re.beat.last);
                end
                if (re.beat.last) begin
                    assert (rx_out_beat.crc_ok == re.crc_ok) else begin
                        errors++;
                        $display("** Error at %0d ns: rx_out crc_ok %b, expected %b",
                                 $time, rx_out_beat.crc_ok, re.crc_ok);
                    end
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : main
        int err0;
        int chk0;
        rst          = 1'b1;
        tx_in_beat   = '0;
        tx_in_valid  = 1'b0;
        tx_out_ready = 1'b0;
        rx_in_beat   = '0;
        rx_in_valid  = 1'b0;
        rx_out_ready = 1'b0;
        main_seed    = 32'h1b04;
        tx_seed      = 32'h1b04 ^ 32'h0001_0000;
        rx_seed      = 32'h1b04 ^ 32'h0002_0000;
        rdy_seed     = 32'h1b04 ^ 32'h0003_0000;
        stall_on     = 1'b0;
        gaps_on      = 1'b0;
        timed_out    = 1'b0;
        errors       = 0;
        checks       = 0;
        repeat (10) @(posedge m_axis);
        rst <= 1'b0;
        @(negedge m_axis);

        err0 = errors;
        chk0 = checks;
        queue_random(20, 1'b1, 1'b0, 1'b0);
        wait_drained("tx append");
        report_test("1 tx append", err0, chk0);

        if (!timed_out) begin
            err0 = errors;
            chk0 = checks;
            queue_random(20, 1'b0, 1'b1, 1'b0);
            wait_drained("rx check");
            report_test("2 rx check good frames", err0, chk0);
        end

        // odd frames carry one flipped bit
        if (!timed_out) begin
            err0 = errors;
            chk0 = checks;
            queue_random(16, 1'b0, 1'b1, 1'b1);
            wait_drained("rx corrupt");
            report_test("3 rx check corrupted frames", err0, chk0);
        end

        if (!timed_out) begin
            err0 = errors;
            chk0 = checks;
            stall_on = 1'b1;
            gaps_on  = 1'b1;
            queue_random(30, 1'b1, 1'b1, 1'b0);
            wait_drained("back-pressure");
            stall_on = 1'b0;
            gaps_on  = 1'b0;
            report_test("4 back-pressure and gaps", err0, chk0);
        end

        // long frames alternate with single-word frames, no idle cycles
        if (!timed_out) begin
            err0 = errors;
            chk0 = checks;
            for (int i = 0; i < 12; i++) begin
                queue_frame((i % 2 == 0) ? 12 - i : 1, 1'b1, 1'b1, 1'b0);
            end
            wait_drained("back-to-back");
            report_test("5 back-to-back frames", err0, chk0);
        end

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/crc_stream_top.sv
/* transmit and receive CRC paths side by side; they share the clock and
   reset but no data, so a loopback is up to the surrounding logic */

`timescale 1ns/1ps
`default_nettype none

module crc_stream_top (
    input  logic                  m_axis,
    input  logic                  rst,

    // transmit path, CRC words are appended to each frame
    input  crc_pkg::stream_beat_t tx_in_beat,
    input  logic                  tx_in_valid,
    output logic                  tx_in_ready,
    output crc_pkg::stream_beat_t tx_out_beat,
    output logic                  tx_out_valid,
    input  logic                  tx_out_ready,

    // receive path, frames are checked and passed on unchanged
    input  crc_pkg::stream_beat_t rx_in_beat,
    input  logic                  rx_in_valid,
    output logic                  rx_in_ready,
    output crc_pkg::check_beat_t  rx_out_beat,
    output logic                  rx_out_valid,
    input  logic                  rx_out_ready
);

    crc_append u_crc_append (
        .m_axis    (m_axis),
        .rst       (rst),
        .in_beat   (tx_in_beat),
        .in_valid  (tx_in_valid),
        .in_ready  (tx_in_ready),
        .out_beat  (tx_out_beat),
        .out_valid (tx_out_valid),
        .out_ready (tx_out_ready)
    );

    crc_check u_crc_check (
        .m_axis    (m_axis),
        .rst       (rst),
        .in_beat   (rx_in_beat),
        .in_valid  (rx_in_valid),
        .in_ready  (rx_in_ready),
        .out_beat  (rx_out_beat),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready)
    );

endmodule

`default_nettype wire

// File: hw/crc_check/crc_check.sv
/* forwards received words unchanged, one cycle later; crc_ok is valid only
   with last and is set when the residue over the frame and its CRC words is
   zero, so the CRC words must still be in the frame */

`timescale 1ns/1ps
`default_nettype none

`include "crc_defs.svh"

module crc_check (
    input  logic                  m_axis,
    input  logic                  rst,
    input  crc_pkg::stream_beat_t in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output crc_pkg::check_beat_t  out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import crc_pkg::*;

    stream_beat_t      out_reg;
    logic              frame_start;
    logic              in_fire;
    logic [`CRC_W-1:0] residue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign in_ready = !out_valid || out_ready;
    assign in_fire  = in_valid && in_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // residue
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    crc_engine #(
        .CRC_WIDTH  (`CRC_W),
        .DATA_WIDTH (`CRC_DATA_W)
    ) u_crc_engine (
        .m_axis (m_axis),
        .rst    (rst),
        .clear  (frame_start && in_fire),
        .en     (in_fire),
        .data   (in_beat.data),
        .crc    (residue)
    );

    // the engine and the output register load on the same transfer, so the
    // residue always includes the word that is currently on the output
    always_ff @(posedge m_axis) begin
        if (rst) begin
            frame_start <= 1'b1;
        end else if (in_fire) begin
            frame_start <= in_beat.last;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge m_axis) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_fire) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge m_axis) begin
        if (in_fire) begin
            out_reg <= in_beat;
        end
    end

    // a stalled output blocks the input, so the residue cannot move under it
    assign out_beat.beat   = out_reg;
    assign out_beat.crc_ok = out_reg.last && (residue == '0);

    a_valid_held : assert property (
        @(posedge m_axis) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("crc_check: output word dropped or changed before it was taken");

endmodule

`default_nettype wire

// File: hw/crc_append/crc_append.sv
/* forwards a frame and then sends its CRC as `CRC_WORDS extra words, most
   significant first; the data word with last goes out with last cleared and
   only the final CRC word carries last; input is stalled while the CRC goes out */

`timescale 1ns/1ps
`default_nettype none

`include "crc_defs.svh"

module crc_append (
    input  logic                  m_axis,
    input  logic                  rst,
    input  crc_pkg::stream_beat_t in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output crc_pkg::stream_beat_t out_beat,
    output logic                  out_valid,
    input  logic                  out_ready
);

    import crc_pkg::*;

    localparam int CNT_W = (`CRC_WORDS > 1) ? $clog2(`CRC_WORDS) : 1;
    localparam logic [CNT_W-1:0] LAST_IDX = CNT_W'(`CRC_WORDS - 1);

    append_state_t          state;
    logic [CNT_W-1:0]       crc_idx;
    logic                   frame_start;
    logic                   out_free;
    logic                   in_fire;
    logic [`CRC_W-1:0]      crc_val;
    logic [`CRC_DATA_W-1:0] crc_word;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // handshake
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the output register can take a new word when it is empty or being drained
    assign out_free = !out_valid || out_ready;
    assign in_ready = (state == APPEND_DATA) && out_free;
    assign in_fire  = in_valid && in_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // CRC of the frame
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    crc_engine #(
        .CRC_WIDTH  (`CRC_W),
        .DATA_WIDTH (`CRC_DATA_W)
    ) u_crc_engine (
        .m_axis (m_axis),
        .rst    (rst),
        .clear  (frame_start && in_fire),
        .en     (in_fire),
        .data   (in_beat.data),
        .crc    (crc_val)
    );

    // the engine is frozen during APPEND_CRC since no input word is accepted
    assign crc_word = crc_val[(`CRC_WORDS - 1 - crc_idx) * `CRC_DATA_W +: `CRC_DATA_W];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM and output register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge m_axis) begin
        if (rst) begin
            state       <= APPEND_DATA;
            crc_idx     <= '0;
            frame_start <= 1'b1;
            out_valid   <= 1'b0;
        end else begin
            case (state)
                APPEND_DATA: begin
                    if (in_fire) begin
                        out_valid   <= 1'b1;
                        frame_start <= in_beat.last;
                        if (in_beat.last) begin
                            state <= APPEND_CRC;
                        end
                    end else if (out_ready) begin
                        out_valid <= 1'b0;
                    end
                end
                APPEND_CRC: begin
                    // one CRC word per free slot in the output register
                    if (out_free) begin
                        out_valid <= 1'b1;
                        if (crc_idx == LAST_IDX) begin
                            crc_idx <= '0;
                            state   <= APPEND_DATA;
                        end else begin
                            crc_idx <= crc_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= APPEND_DATA;
                end
            endcase
        end
    end

    // payload register, loaded together with out_valid above
    always_ff @(posedge m_axis) begin
        if (state == APPEND_CRC) begin
            if (out_free) begin
                out_beat.data <= crc_word;
                out_beat.last <= (crc_idx == LAST_IDX);
            end
        end else if (in_fire) begin
            out_beat.data <= in_beat.data;
            out_beat.last <= 1'b0;
        end
    end

    a_out_stable : assert property (
        @(posedge m_axis) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
    ) else $error("crc_append: output word changed while stalled");

endmodule

`default_nettype wire

// File: hw/crc_engine.sv
/* running CRC, MSB first, no reflection and no final XOR; CRC_WIDTH must be
   8, 16, 32 or 64 and a whole multiple of DATA_WIDTH, otherwise elaboration
   stops; clear is only honoured together with en */

`timescale 1ns/1ps
`default_nettype none

`include "crc_defs.svh"

module crc_engine #(
    parameter int CRC_WIDTH  = 32,
    parameter int DATA_WIDTH = 16
) (
    input  logic                  m_axis,
    input  logic                  rst,
    input  logic                  clear,
    input  logic                  en,
    input  logic [DATA_WIDTH-1:0] data,
    output logic [CRC_WIDTH-1:0]  crc
);

    // polynomials without the implicit top term
    // 8: x^8+x^2+x+1, 16: x^16+x^12+x^5+1, 32: the MPEG-2 one, 64: x^64+x^4+x^3+x+1
    localparam logic [63:0] POLY_FULL =
        (CRC_WIDTH == 8)  ? 64'h0000_0000_0000_0007 :
        (CRC_WIDTH == 16) ? 64'h0000_0000_0000_1021 :
        (CRC_WIDTH == 32) ? 64'h0000_0000_04C1_1DB7 :
                            64'h0000_0000_0000_001B;
    localparam logic [CRC_WIDTH-1:0] POLY = CRC_WIDTH'(POLY_FULL);
    localparam logic [CRC_WIDTH-1:0] SEED = `CRC_SEED;

    if (!(CRC_WIDTH inside {8, 16, 32, 64})) begin : g_bad_crc_width
        $error("crc_engine: CRC_WIDTH must be 8, 16, 32 or 64");
    end

    if ((CRC_WIDTH % DATA_WIDTH) != 0) begin : g_bad_data_width
        $error("crc_engine: CRC_WIDTH must be a whole multiple of DATA_WIDTH");
    end

    // folds one word into the register one bit at a time, MSB first
    function automatic logic [CRC_WIDTH-1:0] fold_word(
        input logic [CRC_WIDTH-1:0]  crc_in,
        input logic [DATA_WIDTH-1:0] word
    );
        logic [CRC_WIDTH-1:0] acc;
        logic                 fb;
        acc = crc_in;
        for (int i = DATA_WIDTH - 1; i >= 0; i--) begin
            fb  = acc[CRC_WIDTH-1] ^ word[i];
            acc = {acc[CRC_WIDTH-2:0], 1'b0} ^ (fb ? POLY : '0);
        end
        return acc;
    endfunction

    logic [CRC_WIDTH-1:0] base;

    // a new frame starts from the seed instead of the previous residue
    assign base = clear ? SEED : crc;

    always_ff @(posedge m_axis) begin
        if (rst) begin
            crc <= SEED;
        end else if (en) begin
            crc <= fold_word(base, data);
        end
    end

    // the owning block must only restart the register on an accepted word
    a_clear_with_en : assert property (
        @(posedge m_axis) disable iff (rst)
        clear |-> en
    ) else $error("crc_engine: clear raised without en");

endmodule

`default_nettype wire

// File: common/crc_pkg.sv
/* stream payload types and the append FSM states; valid and ready travel
   beside these structs and are not part of them */

`default_nettype none

`include "crc_defs.svh"

package crc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stream payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // one word of a frame, last marks the final word
    typedef struct packed {
        logic [`CRC_DATA_W-1:0] data;
        logic                   last;
    } stream_beat_t;

    // a received word together with the residue check of its frame
    // crc_ok only means something on the word that has last set
    typedef struct packed {
        stream_beat_t beat;
        logic         crc_ok;
    } check_beat_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the transmit block either forwards frame data or emits the CRC words
    typedef enum logic [0:0] {
        APPEND_DATA = 1'b0,
        APPEND_CRC  = 1'b1
    } append_state_t;

endpackage

`default_nettype wire

// File: common/crc_defs.svh
/* widths for the CRC stream blocks; CRC_W must be 8, 16, 32 or 64 and a
   whole multiple of CRC_DATA_W, which the CRC engine checks at elaboration */

`ifndef CRC_DEFS_SVH
`define CRC_DEFS_SVH

`default_nettype none

// width of one stream word
`define CRC_DATA_W 16

// width of the CRC register and of the appended checksum
`define CRC_W 32

// number of stream words that carry one CRC
`define CRC_WORDS (`CRC_W / `CRC_DATA_W)

// the register starts at all ones, whatever its width
`define CRC_SEED ('1)

`default_nettype wire

`endif
